//--- source/lenet_defines.svh
`ifndef LENET_DEFINES_SVH
`define LENET_DEFINES_SVH

// ----------------------------------------
// Tap engine sizing
// ----------------------------------------

`define LENET_TAPS      8   // Tap weight registers.
`define LENET_DATA_W    8   // Pixel and weight width.

// Holds 16 full-scale 16-bit products.
`define LENET_ACC_W     20

// ----------------------------------------
// Requantize
// ----------------------------------------

`define LENET_OUT_W     8   // Result byte.
`define LENET_OUT_SHIFT 8   // Right shift before saturation.

`endif

//--- source/lenet_pkg.sv
`include "lenet_defines.svh"

`default_nettype none

package lenet_pkg;

    // ----------------------------------------
    // Host command word
    // ----------------------------------------

    // Codes 2'b00 and 2'b11 are dropped by decode.
    typedef enum logic [1:0] {
        OP_LOAD_WEIGHT = 2'b01,
        OP_MAC         = 2'b10
    } mac_op_e;

    typedef struct packed {
        mac_op_e                        op;
        logic [$clog2(`LENET_TAPS)-1:0] tap;
        logic [2:0]                     unused;
        logic [`LENET_DATA_W-1:0]       weight;
    } cmd_load_t;

    typedef struct packed {
        mac_op_e                        op;
        logic [$clog2(`LENET_TAPS)-1:0] tap;
        logic                           last;    // Closes the window.
        logic [1:0]                     unused;
        logic [`LENET_DATA_W-1:0]       pixel;
    } cmd_mac_t;

    // Op sits in bits 15:14 of both views.
    typedef union packed {
        cmd_load_t as_load;
        cmd_mac_t  as_mac;
    } mac_cmd_u;

    // ----------------------------------------
    // Stage to stage
    // ----------------------------------------

    typedef struct packed {
        logic                           is_load;
        logic                           is_mac;
        logic [$clog2(`LENET_TAPS)-1:0] tap;
        logic                           last;
        logic [`LENET_DATA_W-1:0]       data;    // Weight or pixel.
    } exec_op_t;

    typedef struct packed {
        logic [`LENET_ACC_W-1:0] value;
    } window_sum_t;

endpackage

`default_nettype wire

//--- source/approx_mul.sv
`default_nettype none

module approx_mul (
    input  wire logic [7:0]  x,
    input  wire logic [7:0]  y,
    output logic      [15:0] z
);

    logic [7:0]  pp [1:8];   // Row i is gated by x[i-1].
    logic [12:0] w  [1:6];   // Compressed rows 1 to 6.

    for (genvar i = 1; i <= 8; i++) begin : g_row
        assign pp[i] = y & {8{x[i-1]}};
    end

    // ----------------------------------------
    // Sparse compression of the low rows
    // ----------------------------------------

    always_comb begin
        w = '{default: '0};

        w[1][3]  = pp[1][3] & pp[2][2];
        w[1][5]  = pp[1][5] & pp[2][4];
        w[1][6]  = pp[1][5] ^ pp[2][4];
        w[1][8]  = pp[3][5] & pp[4][4];
        w[1][9]  = pp[3][7] | pp[4][6];
        w[1][10] = pp[3][7] & pp[4][6];
        w[1][11] = pp[5][6] & pp[6][5];
        w[1][12] = pp[6][7];

        w[2][3]  = pp[1][3] | pp[2][2];
        w[2][5]  = pp[1][5] | pp[2][4];
        w[2][6]  = pp[3][3] & pp[4][2];
        w[2][8]  = pp[3][5] ^ pp[4][4];
        w[2][9]  = pp[5][4] & pp[6][3];
        w[2][10] = pp[4][7];
        w[2][11] = pp[5][7] & pp[6][6];

        w[3][3]  = pp[3][1] ^ pp[4][0];
        w[3][6]  = pp[5][1] ^ pp[6][0];
        w[3][8]  = pp[3][6] | pp[4][5];
        w[3][9]  = pp[5][5] & pp[6][4];
        w[3][10] = pp[5][6] ^ pp[6][5];
        w[3][11] = pp[5][7] | pp[6][6];

        // Last three words carry one or two bits each.
        w[4][8]  = pp[5][3] & pp[6][2];
        w[4][9]  = pp[5][5] | pp[6][4];
        w[5][8]  = pp[5][3] | pp[6][2];
        w[6][8]  = pp[5][4] ^ pp[6][3];
    end

    // ----------------------------------------
    // Final sum
    // ----------------------------------------

    // Rows 7 and 8 go in exact.
    assign z = {pp[7], 6'b0} + {pp[8], 7'b0}
             + w[1] + w[2] + w[3]
             + w[4] + w[5] + w[6];

endmodule

`default_nettype wire

//--- source/mac_decode.sv
`default_nettype none

module mac_decode (
    input  wire logic               clk,
    input  wire logic               reset,
    input  wire lenet_pkg::mac_cmd_u cmd,
    input  wire logic               cmd_req,
    output logic                    cmd_ack,
    output lenet_pkg::exec_op_t     op,
    output logic                    op_valid,
    input  wire logic               op_ready
);

    lenet_pkg::exec_op_t dec;
    logic                take;
    logic                known;

    // New request, and the holding register is empty or draining.
    assign take  = cmd_req && !cmd_ack && (!op_valid || op_ready);
    assign known = dec.is_load || dec.is_mac;

    always_comb begin
        dec.is_load = (cmd.as_load.op == lenet_pkg::OP_LOAD_WEIGHT);
        dec.is_mac  = (cmd.as_mac.op == lenet_pkg::OP_MAC);
        dec.tap     = cmd.as_load.tap;      // Same bits in the mac view.
        dec.last    = cmd.as_mac.last;
        dec.data    = cmd.as_load.weight;   // Pixel shares the low byte.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_ack  <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            if (take) begin
                cmd_ack <= 1'b1;
            end else if (!cmd_req) begin
                cmd_ack <= 1'b0;   // Req seen low.
            end

            if (take) begin
                op_valid <= known;   // Unknown codes are acked only.
            end else if (op_ready) begin
                op_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && known) begin
            op <= dec;
        end
    end

endmodule

`default_nettype wire

//--- source/mac_execute.sv
`include "lenet_defines.svh"

`default_nettype none

module mac_execute (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire lenet_pkg::exec_op_t  op,
    input  wire logic                 op_valid,
    output logic                      op_ready,
    output lenet_pkg::window_sum_t    sum,
    output logic                      sum_valid,
    input  wire logic                 sum_ready
);

    logic [`LENET_DATA_W-1:0]   weight [`LENET_TAPS];
    logic [`LENET_ACC_W-1:0]    acc;
    logic [`LENET_ACC_W-1:0]    acc_next;
    logic [2*`LENET_DATA_W-1:0] prod;
    logic                       accept;

    // Stall while a closed window is unread.
    assign op_ready = !sum_valid;
    assign accept   = op_valid && op_ready;

    // ----------------------------------------
    // Multiply and accumulate
    // ----------------------------------------

    approx_mul u_mul (
        .x (weight[op.tap]),
        .y (op.data),
        .z (prod)
    );

    assign acc_next = acc + {{(`LENET_ACC_W - 2*`LENET_DATA_W){1'b0}}, prod};

    always_ff @(posedge clk) begin
        if (reset) begin
            weight    <= '{default: '0};
            acc       <= '0;
            sum_valid <= 1'b0;
        end else begin
            if (sum_valid && sum_ready) begin
                sum_valid <= 1'b0;
            end

            if (accept && op.is_load) begin
                weight[op.tap] <= op.data;
            end

            if (accept && op.is_mac) begin
                if (op.last) begin
                    acc       <= '0;   // Next window starts clean.
                    sum_valid <= 1'b1;
                end else begin
                    acc <= acc_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && op.is_mac && op.last) begin
            sum.value <= acc_next;
        end
    end

endmodule

`default_nettype wire

//--- source/mac_result.sv
`include "lenet_defines.svh"

`default_nettype none

module mac_result (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire lenet_pkg::window_sum_t  sum,
    input  wire logic                    sum_valid,
    output logic                         sum_ready,
    output logic [`LENET_OUT_W-1:0]      result,
    output logic                         res_req,
    input  wire logic                    res_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_ACK_LOW
    } res_state_e;

    res_state_e              state;
    logic [`LENET_ACC_W-1:0] shifted;
    logic [`LENET_OUT_W-1:0] quant;

    // ----------------------------------------
    // Requantize
    // ----------------------------------------

    assign shifted = sum.value >> `LENET_OUT_SHIFT;
    assign quant   = (|shifted[`LENET_ACC_W-1:`LENET_OUT_W]) ? '1
                                                             : shifted[`LENET_OUT_W-1:0];

    // ----------------------------------------
    // Output handshake
    // ----------------------------------------

    assign sum_ready = (state == ST_IDLE);
    assign res_req   = (state == ST_REQ);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (sum_valid) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (res_ack) begin
                        state <= ST_ACK_LOW;   // Drop req.
                    end
                end
                ST_ACK_LOW: begin
                    if (!res_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Held for the whole request phase.
    always_ff @(posedge clk) begin
        if (sum_valid && sum_ready) begin
            result <= quant;
        end
    end

endmodule

`default_nettype wire

//--- source/mac_top.sv
`include "lenet_defines.svh"

`default_nettype none

module mac_top (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire lenet_pkg::mac_cmd_u  cmd,
    input  wire logic                 cmd_req,
    output logic                      cmd_ack,
    output logic [`LENET_OUT_W-1:0]   result,
    output logic                      res_req,
    input  wire logic                 res_ack
);

    lenet_pkg::exec_op_t    op;
    logic                   op_valid;
    logic                   op_ready;
    lenet_pkg::window_sum_t sum;
    logic                   sum_valid;
    logic                   sum_ready;

    mac_decode u_decode (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .op       (op),
        .op_valid (op_valid),
        .op_ready (op_ready)
    );

    mac_execute u_execute (
        .clk       (clk),
        .reset     (reset),
        .op        (op),
        .op_valid  (op_valid),
        .op_ready  (op_ready),
        .sum       (sum),
        .sum_valid (sum_valid),
        .sum_ready (sum_ready)
    );

    mac_result u_result (
        .clk       (clk),
        .reset     (reset),
        .sum       (sum),
        .sum_valid (sum_valid),
        .sum_ready (sum_ready),
        .result    (result),
        .res_req   (res_req),
        .res_ack   (res_ack)
    );

endmodule

`default_nettype wire

//--- testbench/mac_assert.sv
`include "lenet_defines.svh"

`default_nettype none

module mac_assert (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    cmd_req,
    input  wire logic                    cmd_ack,
    input  wire logic [`LENET_OUT_W-1:0] result,
    input  wire logic                    res_req,
    input  wire logic                    res_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;   // Read by the testbench.

    // ----------------------------------------
    // Handshake rules
    // ----------------------------------------

    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(cmd_ack) |-> $past(cmd_req))
    else begin
        fail_count++;
        $error("cmd_ack rose without cmd_req");
    end

    result_held: assert property (@(posedge clk) disable iff (reset)
        (res_req && $past(res_req)) |-> $stable(result))
    else begin
        fail_count++;
        $error("result changed while res_req was high");
    end

    req_drop_on_ack: assert property (@(posedge clk) disable iff (reset)
        $fell(res_req) |-> $past(res_ack))
    else begin
        fail_count++;
        $error("res_req fell before res_ack");
    end

    // Both links idle right out of reset.
    idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!cmd_ack && !res_req))
    else begin
        fail_count++;
        $error("cmd_ack or res_req high after reset");
    end

endmodule

bind mac_top mac_assert u_assert (
    .clk     (clk),
    .reset   (reset),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .result  (result),
    .res_req (res_req),
    .res_ack (res_ack)
);

`default_nettype wire

//--- testbench/mac_tb.sv
`include "lenet_defines.svh"

`default_nettype none

module mac_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_EXACT   = 4;
    localparam int N_RANDOM  = 40;
    localparam int N_BACKP   = 8;
    localparam int N_WINDOWS = N_EXACT + 2 + N_RANDOM + 1 + N_BACKP;
    // Worst case of one load and one mac per tap in every window.
    localparam int TIMEOUT   = 40 * N_WINDOWS * 2 * `LENET_TAPS + 2000;

    logic                    clk;
    logic                    reset;
    lenet_pkg::mac_cmd_u     cmd;
    logic                    cmd_req;
    logic                    cmd_ack;
    logic [`LENET_OUT_W-1:0] result;
    logic                    res_req;
    logic                    res_ack;

    logic [31:0]              stim_state = 32'h39706c17;
    logic [31:0]              ack_state  = 32'h39706c17;
    logic [`LENET_DATA_W-1:0] ref_w [`LENET_TAPS];
    logic [`LENET_ACC_W-1:0]  ref_acc;
    logic [`LENET_OUT_W-1:0]  expect_q [$];
    logic [`LENET_OUT_W-1:0]  exp_val;
    logic                     slow_ack   = 1'b0;
    logic                     res_req_d  = 1'b0;
    int                       value_errors = 0;
    int                       other_errors = 0;
    int                       results    = 0;
    int                       windows    = 0;
    int                       cycles     = 0;

    mac_top dut0 (
        .clk     (clk),
        .reset   (reset),
        .cmd     (cmd),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack),
        .result  (result),
        .res_req (res_req),
        .res_ack (res_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ----------------------------------------
    // Random source and reference model
    // ----------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_state = lfsr_next(stim_state);
            v = {v[30:0], stim_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] ack_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            ack_state = lfsr_next(ack_state);
            v = {v[30:0], ack_state[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] at(input logic b, input int pos);
        return 16'(b) << pos;
    endfunction

    // Approximate product of weight x and pixel y.
    function automatic logic [15:0] ref_mul(input logic [7:0] x, input logic [7:0] y);
        logic [7:0]  r [1:8];
        logic [15:0] z;
        for (int i = 1; i <= 8; i++) begin
            r[i] = y & {8{x[i-1]}};
        end
        z = (16'(r[7]) << 6) + (16'(r[8]) << 7);
        z += at(r[1][3] & r[2][2], 3) + at(r[1][3] | r[2][2], 3) + at(r[3][1] ^ r[4][0], 3);
        z += at(r[1][5] & r[2][4], 5) + at(r[1][5] | r[2][4], 5);
        z += at(r[1][5] ^ r[2][4], 6) + at(r[3][3] & r[4][2], 6) + at(r[5][1] ^ r[6][0], 6);
        z += at(r[3][5] & r[4][4], 8) + at(r[3][5] ^ r[4][4], 8) + at(r[3][6] | r[4][5], 8);
        z += at(r[5][3] & r[6][2], 8) + at(r[5][3] | r[6][2], 8) + at(r[5][4] ^ r[6][3], 8);
        z += at(r[3][7] | r[4][6], 9) + at(r[5][4] & r[6][3], 9);
        z += at(r[5][5] & r[6][4], 9) + at(r[5][5] | r[6][4], 9);
        z += at(r[3][7] & r[4][6], 10) + at(r[4][7], 10) + at(r[5][6] ^ r[6][5], 10);
        z += at(r[5][6] & r[6][5], 11) + at(r[5][7] & r[6][6], 11) + at(r[5][7] | r[6][6], 11);
        z += at(r[6][7], 12);
        return z;
    endfunction

    function automatic logic [7:0] requant(input logic [`LENET_ACC_W-1:0] a);
        logic [`LENET_ACC_W-1:0] s;
        s = a >> `LENET_OUT_SHIFT;
        return (s > 255) ? 8'hff : s[7:0];
    endfunction

    // ----------------------------------------
    // Host side of the command link
    // ----------------------------------------

    task automatic send_word(input lenet_pkg::mac_cmd_u word);
        cmd     = word;
        cmd_req = 1'b1;
        do begin
            @(posedge clk);
            #2;
        end while (!cmd_ack);
        cmd_req = 1'b0;
        do begin
            @(posedge clk);
            #2;
        end while (cmd_ack);
    endtask

    task automatic load_weight(input int tap, input logic [7:0] w);
        lenet_pkg::mac_cmd_u c;
        c                = '0;
        c.as_load.op     = lenet_pkg::OP_LOAD_WEIGHT;
        c.as_load.tap    = 3'(tap);
        c.as_load.weight = w;
        ref_w[tap]       = w;
        send_word(c);
    endtask

    task automatic mac_pixel(input int tap, input logic [7:0] pixel, input logic last);
        lenet_pkg::mac_cmd_u c;
        c              = '0;
        c.as_mac.op    = lenet_pkg::OP_MAC;
        c.as_mac.tap   = 3'(tap);
        c.as_mac.last  = last;
        c.as_mac.pixel = pixel;
        ref_acc        = ref_acc + 20'(ref_mul(ref_w[tap], pixel));
        if (last) begin
            expect_q.push_back(requant(ref_acc));   // Queued before the DUT can answer.
            ref_acc = '0;
            windows++;
        end
        send_word(c);
    endtask

    task automatic random_window(input int max_len);
        int len;
        len = 1 + int'(stim_bits(3)) % max_len;
        load_weight(int'(stim_bits(3)), 8'(stim_bits(8)));   // Reload between windows.
        for (int i = 0; i < len; i++) begin
            mac_pixel(int'(stim_bits(3)), 8'(stim_bits(8)), i == len - 1);
        end
    endtask

    // ----------------------------------------
    // Result acknowledge, compare, timeout
    // ----------------------------------------

    initial begin
        int delay;
        res_ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (res_req) begin
                delay = int'(ack_bits(3)) + (slow_ack ? 24 : 0);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                res_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #2;
                end while (res_req);
                res_ack = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (res_req && !res_req_d) begin
            results++;
            if (expect_q.size() == 0) begin
                $display("Result 0x%02h arrived with no window pending", result);
                other_errors++;
            end else begin
                exp_val = expect_q.pop_front();
                if (result !== exp_val) begin
                    $display("ERROR result: expected 0x%02h, actual 0x%02h", exp_val, result);
                    value_errors++;
                end
            end
        end
        res_req_d <= res_req;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Run stopped after %0d cycles, %0d results still outstanding",
                     cycles, expect_q.size());
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        reset   = 1'b1;
        cmd     = '0;
        cmd_req = 1'b0;
        ref_acc = '0;
        ref_w   = '{default: '0};
        repeat (8) @(posedge clk);
        #2 reset = 1'b0;

        for (int k = 0; k < N_EXACT; k++) begin
            load_weight(k, 8'(stim_bits(2)) << 6);   // Only bits 6 and 7.
            mac_pixel(k, 8'(stim_bits(8)), 1'b1);
        end

        for (int i = 0; i < 3; i++) begin
            mac_pixel(i, 8'h00, i == 2);
        end
        for (int i = 0; i < 4; i++) begin
            load_weight(i, 8'h00);
        end
        send_word(16'hc4ab);   // Unknown opcode, dropped.
        for (int i = 0; i < 4; i++) begin
            mac_pixel(i, 8'(stim_bits(8)), i == 3);
        end

        for (int k = 0; k < N_RANDOM; k++) begin
            random_window(8);
        end

        for (int i = 0; i < `LENET_TAPS; i++) begin
            load_weight(i, 8'hff);
        end
        for (int i = 0; i < `LENET_TAPS; i++) begin
            mac_pixel(i, 8'hff, i == `LENET_TAPS - 1);
        end

        // Short windows against a slow consumer.
        slow_ack = 1'b1;
        for (int k = 0; k < N_BACKP; k++) begin
            random_window(2);
        end

        while (expect_q.size() != 0 || res_req) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (results != windows) begin
            $display("Got %0d results for %0d closed windows", results, windows);
            other_errors++;
        end

        $display("Errors: %0d value, %0d other, %0d assertion, over %0d results",
                 value_errors, other_errors, dut0.u_assert.fail_count, results);
        if (value_errors + other_errors + dut0.u_assert.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+source
source/lenet_pkg.sv
source/approx_mul.sv
source/mac_decode.sv
source/mac_execute.sv
source/mac_result.sv
source/mac_top.sv
testbench/mac_assert.sv
testbench/mac_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the tap engine testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mac_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vmac_tb +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
